//--- logic/issue_pkg.sv
/*
 * Shared widths, opcode and unit command encodings, and the bundles
 * passed between the decoder, the issue stage and the execution units.
 */

package issue_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    // Decoded instruction kinds accepted by the issue stage
    typedef enum logic [5:0] {
        i_NOP,
        // Immediate arithmetic
        i_LUI, i_AUIPC, i_ADDI, i_XORI, i_ORI, i_ANDI,
        // Register arithmetic
        i_ADD, i_SUB, i_OR, i_AND, i_XOR,
        // Compare, jump and branch
        i_SLTI, i_SLTIU, i_JAL, i_JALR, i_SLT, i_SLTU,
        i_BEQ, i_BNE, i_BLT, i_BGE, i_BLTU, i_BGEU,
        // Shifts
        i_SLLI, i_SRLI, i_SRAI, i_SLL, i_SRL, i_SRA,
        // M extension
        i_MUL, i_MULH, i_MULHU, i_MULHSU, i_DIV, i_DIVU, i_REM, i_REMU,
        // Memory access
        i_LB, i_LH, i_LW, i_LBU, i_LHU, i_SB, i_SH, i_SW
    } opcode_t;

    // Command seen by a unit, c_NONE marks an idle cycle
    typedef enum logic [5:0] {
        c_NONE = 6'd0,
        c_ADD, c_SUB, c_XOR, c_OR, c_AND,
        c_SLT, c_SLTU, c_JAL, c_JALR,
        c_BEQ, c_BNE, c_BLT, c_BGE, c_BLTU, c_BGEU,
        c_SLL, c_SRL, c_SRA,
        c_MUL, c_MULH, c_MULHU, c_MULHSU, c_DIV, c_DIVU, c_REM, c_REMU,
        c_LB, c_LH, c_LW, c_LBU, c_LHU, c_SB, c_SH, c_SW
    } unit_cmd_t;

    // Execution class, muldiv covers both shift/muldiv units
    typedef enum logic [1:0] {
        U_ALU,
        U_BRANCH,
        U_MULDIV,
        U_LSU
    } unit_sel_t;

    typedef struct packed {
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       imm;
        logic [XLEN-1:0]       addr;
        opcode_t               opcode;
    } dec_instr_t;

    typedef struct packed {
        logic [XLEN-1:0]       arg0;
        logic [XLEN-1:0]       arg1;
        logic [XLEN-1:0]       addr;
        logic [XLEN-1:0]       imm;
        unit_cmd_t             cmd;
        logic [REG_ADDR_W-1:0] rd;
    } unit_req_t;

    // Level busy flags, one per unit port
    typedef struct packed {
        logic alu;
        logic branch;
        logic muldiv0;
        logic muldiv1;
        logic lsu;
    } unit_busy_t;

    // Value of a unit port that carries no request
    localparam unit_req_t REQ_IDLE = '{
        arg0: '0,
        arg1: '0,
        addr: '0,
        imm:  '0,
        cmd:  c_NONE,
        rd:   '0
    };

endpackage

//--- logic/issue_hold.sv
/*
 * Hold register of the issue stage. Captures one decoded instruction and
 * keeps it while the dispatch logic stalls on busy units.
 */

`timescale 1ns/10ps

module issue_hold (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   i_flush,
    input  logic                                   i_valid,
    input  issue_pkg::dec_instr_t                  i_instr,
    input  logic                                   i_stall,
    output issue_pkg::dec_instr_t                  o_held,
    output logic                                   o_held_valid,
    output logic [issue_pkg::REG_ADDR_W-1:0]       o_reg_ra0,
    output logic [issue_pkg::REG_ADDR_W-1:0]       o_reg_ra1,
    output logic                                   o_busy
);

    // Occupancy flag, flush drops whatever sits here
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_held_valid <= 1'b0;
        end else if (i_flush) begin
            o_held_valid <= 1'b0;
        end else if (!i_stall) begin
            o_held_valid <= i_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_stall) begin
            o_held <= i_instr;
        end
    end

    // Register file is read straight from the held sources
    assign o_reg_ra0 = o_held.rs1;
    assign o_reg_ra1 = o_held.rs2;
    assign o_busy    = i_stall;

endmodule

//--- logic/issue_route.sv
/*
 * Opcode router. Maps the held opcode to its execution class, the
 * command the unit runs, and whether arg1 takes the immediate.
 */

`timescale 1ns/10ps

module issue_route (
    input  issue_pkg::opcode_t   i_opcode,
    output issue_pkg::unit_sel_t o_unit,
    output issue_pkg::unit_cmd_t o_cmd,
    output logic                 o_use_imm
);

    always_comb begin
        case (i_opcode)
            // NOP runs as an add with rd forced to zero downstream
            issue_pkg::i_NOP, issue_pkg::i_LUI, issue_pkg::i_AUIPC,
            issue_pkg::i_ADDI, issue_pkg::i_ADD: o_cmd = issue_pkg::c_ADD;
            issue_pkg::i_SUB:                    o_cmd = issue_pkg::c_SUB;
            issue_pkg::i_XORI, issue_pkg::i_XOR: o_cmd = issue_pkg::c_XOR;
            issue_pkg::i_ORI, issue_pkg::i_OR:   o_cmd = issue_pkg::c_OR;
            issue_pkg::i_ANDI, issue_pkg::i_AND: o_cmd = issue_pkg::c_AND;

            issue_pkg::i_SLTI, issue_pkg::i_SLT:   o_cmd = issue_pkg::c_SLT;
            issue_pkg::i_SLTIU, issue_pkg::i_SLTU: o_cmd = issue_pkg::c_SLTU;
            issue_pkg::i_JAL:                      o_cmd = issue_pkg::c_JAL;
            issue_pkg::i_JALR:                     o_cmd = issue_pkg::c_JALR;
            issue_pkg::i_BEQ:                      o_cmd = issue_pkg::c_BEQ;
            issue_pkg::i_BNE:                      o_cmd = issue_pkg::c_BNE;
            issue_pkg::i_BLT:                      o_cmd = issue_pkg::c_BLT;
            issue_pkg::i_BGE:                      o_cmd = issue_pkg::c_BGE;
            issue_pkg::i_BLTU:                     o_cmd = issue_pkg::c_BLTU;
            issue_pkg::i_BGEU:                     o_cmd = issue_pkg::c_BGEU;

            issue_pkg::i_SLLI, issue_pkg::i_SLL: o_cmd = issue_pkg::c_SLL;
            issue_pkg::i_SRLI, issue_pkg::i_SRL: o_cmd = issue_pkg::c_SRL;
            issue_pkg::i_SRAI, issue_pkg::i_SRA: o_cmd = issue_pkg::c_SRA;
            issue_pkg::i_MUL:                    o_cmd = issue_pkg::c_MUL;
            issue_pkg::i_MULH:                   o_cmd = issue_pkg::c_MULH;
            issue_pkg::i_MULHU:                  o_cmd = issue_pkg::c_MULHU;
            issue_pkg::i_MULHSU:                 o_cmd = issue_pkg::c_MULHSU;
            issue_pkg::i_DIV:                    o_cmd = issue_pkg::c_DIV;
            issue_pkg::i_DIVU:                   o_cmd = issue_pkg::c_DIVU;
            issue_pkg::i_REM:                    o_cmd = issue_pkg::c_REM;
            issue_pkg::i_REMU:                   o_cmd = issue_pkg::c_REMU;

            issue_pkg::i_LB:  o_cmd = issue_pkg::c_LB;
            issue_pkg::i_LH:  o_cmd = issue_pkg::c_LH;
            issue_pkg::i_LW:  o_cmd = issue_pkg::c_LW;
            issue_pkg::i_LBU: o_cmd = issue_pkg::c_LBU;
            issue_pkg::i_LHU: o_cmd = issue_pkg::c_LHU;
            issue_pkg::i_SB:  o_cmd = issue_pkg::c_SB;
            issue_pkg::i_SH:  o_cmd = issue_pkg::c_SH;
            issue_pkg::i_SW:  o_cmd = issue_pkg::c_SW;
            default:          o_cmd = issue_pkg::c_NONE;
        endcase

        // Class follows from the command groups above
        if (o_cmd inside {issue_pkg::c_SLT, issue_pkg::c_SLTU, issue_pkg::c_JAL,
                          issue_pkg::c_JALR, issue_pkg::c_BEQ, issue_pkg::c_BNE,
                          issue_pkg::c_BLT, issue_pkg::c_BGE, issue_pkg::c_BLTU,
                          issue_pkg::c_BGEU}) begin
            o_unit = issue_pkg::U_BRANCH;
        end else if (o_cmd inside {[issue_pkg::c_SLL : issue_pkg::c_REMU]}) begin
            o_unit = issue_pkg::U_MULDIV;
        end else if (o_cmd inside {[issue_pkg::c_LB : issue_pkg::c_SW]}) begin
            o_unit = issue_pkg::U_LSU;
        end else begin
            o_unit = issue_pkg::U_ALU;
        end

        if (!$isunknown(i_opcode)) begin
            assert (o_cmd != issue_pkg::c_NONE)
                else $error("opcode %0d has no unit command", i_opcode);
        end
    end

    // Immediate forms plus upper-immediate and jumps read imm as arg1
    assign o_use_imm = i_opcode inside {
        issue_pkg::i_LUI, issue_pkg::i_AUIPC, issue_pkg::i_ADDI, issue_pkg::i_XORI,
        issue_pkg::i_ORI, issue_pkg::i_ANDI, issue_pkg::i_SLTI, issue_pkg::i_SLTIU,
        issue_pkg::i_JAL, issue_pkg::i_JALR, issue_pkg::i_SLLI, issue_pkg::i_SRLI,
        issue_pkg::i_SRAI
    };

endmodule

//--- logic/unit_dispatch.sv
/*
 * Dispatch side of the issue stage. Assembles operands, picks a free unit
 * for the held instruction and registers the request on that unit port.
 */

`timescale 1ns/10ps

module unit_dispatch (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             i_flush,
    input  issue_pkg::dec_instr_t            i_held,
    input  logic                             i_held_valid,
    input  issue_pkg::unit_sel_t             i_unit,
    input  issue_pkg::unit_cmd_t             i_cmd,
    input  logic                             i_use_imm,
    input  logic [issue_pkg::XLEN-1:0]       i_reg_rd0,
    input  logic [issue_pkg::XLEN-1:0]       i_reg_rd1,
    input  issue_pkg::unit_busy_t            i_busy,
    output logic                             o_stall,
    output issue_pkg::unit_req_t             o_alu,
    output issue_pkg::unit_req_t             o_branch,
    output issue_pkg::unit_req_t             o_muldiv0,
    output issue_pkg::unit_req_t             o_muldiv1,
    output issue_pkg::unit_req_t             o_lsu
);

    issue_pkg::unit_req_t req;
    logic                 pick_alu;
    logic                 pick_branch;
    logic                 pick_md0;
    logic                 pick_md1;
    logic                 pick_lsu;

    // Request to a port that was not picked is the idle word
    function automatic issue_pkg::unit_req_t gate_req(input logic pick,
                                                      input issue_pkg::unit_req_t r);
        return pick ? r : issue_pkg::REQ_IDLE;
    endfunction

    always_comb begin
        req.arg0 = i_reg_rd0;
        req.arg1 = i_use_imm ? i_held.imm : i_reg_rd1;
        req.addr = i_held.addr;
        req.imm  = i_held.imm;
        req.cmd  = i_cmd;
        // NOP writes back nowhere
        req.rd   = (i_held.opcode == issue_pkg::i_NOP) ? '0 : i_held.rd;
    end

    // Target selection, muldiv0 has priority over muldiv1
    always_comb begin
        pick_alu    = 1'b0;
        pick_branch = 1'b0;
        pick_md0    = 1'b0;
        pick_md1    = 1'b0;
        pick_lsu    = 1'b0;
        if (i_held_valid) begin
            case (i_unit)
                issue_pkg::U_ALU:    pick_alu    = !i_busy.alu;
                issue_pkg::U_BRANCH: pick_branch = !i_busy.branch;
                issue_pkg::U_MULDIV: begin
                    pick_md0 = !i_busy.muldiv0;
                    pick_md1 = i_busy.muldiv0 && !i_busy.muldiv1;
                end
                issue_pkg::U_LSU:    pick_lsu    = !i_busy.lsu;
            endcase
        end
    end

    assign o_stall = i_held_valid &&
                     !(pick_alu || pick_branch || pick_md0 || pick_md1 || pick_lsu);

    // Every port is rewritten each cycle, so a request lasts one cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_alu     <= issue_pkg::REQ_IDLE;
            o_branch  <= issue_pkg::REQ_IDLE;
            o_muldiv0 <= issue_pkg::REQ_IDLE;
            o_muldiv1 <= issue_pkg::REQ_IDLE;
            o_lsu     <= issue_pkg::REQ_IDLE;
        end else begin
            o_alu     <= gate_req(pick_alu && !i_flush, req);
            o_branch  <= gate_req(pick_branch && !i_flush, req);
            o_muldiv0 <= gate_req(pick_md0 && !i_flush, req);
            o_muldiv1 <= gate_req(pick_md1 && !i_flush, req);
            o_lsu     <= gate_req(pick_lsu && !i_flush, req);
        end
    end

    a_one_port: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({o_alu.cmd != issue_pkg::c_NONE, o_branch.cmd != issue_pkg::c_NONE,
                  o_muldiv0.cmd != issue_pkg::c_NONE, o_muldiv1.cmd != issue_pkg::c_NONE,
                  o_lsu.cmd != issue_pkg::c_NONE}))
        else $error("more than one unit port carries a command");

endmodule

//--- logic/issuer_top.sv
/*
 * Issue stage top. Hold register, opcode router and unit dispatch;
 * takes decoded instructions and sends them to the five unit ports.
 */

`timescale 1ns/10ps

module issuer_top (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             i_flush,
    input  logic                             i_valid,
    input  issue_pkg::dec_instr_t            i_instr,
    output logic                             o_busy,
    output logic [issue_pkg::REG_ADDR_W-1:0] o_reg_ra0,
    output logic [issue_pkg::REG_ADDR_W-1:0] o_reg_ra1,
    input  logic [issue_pkg::XLEN-1:0]       i_reg_rd0,
    input  logic [issue_pkg::XLEN-1:0]       i_reg_rd1,
    input  issue_pkg::unit_busy_t            i_busy,
    output issue_pkg::unit_req_t             o_alu,
    output issue_pkg::unit_req_t             o_branch,
    output issue_pkg::unit_req_t             o_muldiv0,
    output issue_pkg::unit_req_t             o_muldiv1,
    output issue_pkg::unit_req_t             o_lsu
);

    issue_pkg::dec_instr_t held;
    logic                  held_valid;
    logic                  stall;
    issue_pkg::unit_sel_t  unit;
    issue_pkg::unit_cmd_t  cmd;
    logic                  use_imm;

    issue_hold issue_hold_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_flush     (i_flush),
        .i_valid     (i_valid),
        .i_instr     (i_instr),
        .i_stall     (stall),
        .o_held      (held),
        .o_held_valid(held_valid),
        .o_reg_ra0   (o_reg_ra0),
        .o_reg_ra1   (o_reg_ra1),
        .o_busy      (o_busy)
    );

    issue_route issue_route_i (
        .i_opcode (held.opcode),
        .o_unit   (unit),
        .o_cmd    (cmd),
        .o_use_imm(use_imm)
    );

    unit_dispatch unit_dispatch_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_flush     (i_flush),
        .i_held      (held),
        .i_held_valid(held_valid),
        .i_unit      (unit),
        .i_cmd       (cmd),
        .i_use_imm   (use_imm),
        .i_reg_rd0   (i_reg_rd0),
        .i_reg_rd1   (i_reg_rd1),
        .i_busy      (i_busy),
        .o_stall     (stall),
        .o_alu       (o_alu),
        .o_branch    (o_branch),
        .o_muldiv0   (o_muldiv0),
        .o_muldiv1   (o_muldiv1),
        .o_lsu       (o_lsu)
    );

endmodule

//--- verification/issuer_tb.sv
/*
 * Testbench for the issue stage. Sends decoded instructions, models the
 * register file, keeps the expected issue order in a queue and checks
 * every unit port with concurrent assertions.
 */

`timescale 1ns/10ps

module issuer_tb;

    typedef struct packed {
        issue_pkg::unit_sel_t unit;
        issue_pkg::unit_req_t req;
    } exp_t;

    logic                             clk = 1'b0;
    logic                             rst_n;
    logic                             i_flush;
    logic                             i_valid;
    issue_pkg::dec_instr_t            i_instr;
    logic                             o_busy;
    logic [issue_pkg::REG_ADDR_W-1:0] o_reg_ra0;
    logic [issue_pkg::REG_ADDR_W-1:0] o_reg_ra1;
    logic [issue_pkg::XLEN-1:0]       i_reg_rd0;
    logic [issue_pkg::XLEN-1:0]       i_reg_rd1;
    issue_pkg::unit_busy_t            i_busy;
    issue_pkg::unit_req_t             o_alu;
    issue_pkg::unit_req_t             o_branch;
    issue_pkg::unit_req_t             o_muldiv0;
    issue_pkg::unit_req_t             o_muldiv1;
    issue_pkg::unit_req_t             o_lsu;

    exp_t                 q[$];
    exp_t                 head;
    logic                 head_valid;
    logic                 seen_valid;
    int                   accept_cnt;
    logic                 rand_busy;
    int                   fails;
    int                   timeouts;
    int                   tests;
    logic [4:0]           active;
    logic                 idle_dirty;
    issue_pkg::unit_req_t obs;
    issue_pkg::unit_sel_t obs_unit;
    issue_pkg::unit_sel_t tail_unit;
    logic                 target_free;

    issuer_top issuer_top_i (.*);

    always #50 clk = ~clk;

    // Register a reads back as its index in every byte, so x0 reads zero
    function automatic logic [issue_pkg::XLEN-1:0] reg_value(input logic [4:0] a);
        return {4{3'b000, a}};
    endfunction

    assign i_reg_rd0 = reg_value(o_reg_ra0);
    assign i_reg_rd1 = reg_value(o_reg_ra1);

    function automatic logic idle_bad(input issue_pkg::unit_req_t r);
        return r.cmd == issue_pkg::c_NONE && r != '0;
    endfunction

    function automatic string port_name(input logic [4:0] a);
        case (a)
            5'b10000: return "o_alu";
            5'b01000: return "o_branch";
            5'b00100: return "o_muldiv0";
            5'b00010: return "o_muldiv1";
            default:  return "o_lsu";
        endcase
    endfunction

    // Expected issue taken from the opcode name, immediate forms drop their I
    function automatic exp_t expect_of(input issue_pkg::dec_instr_t d);
        exp_t                 e;
        issue_pkg::opcode_t   op;
        issue_pkg::unit_cmd_t k;
        string                n;
        string                base;
        string                p1;
        string                p3;
        logic                 imm_form;
        op = d.opcode;
        n = op.name();
        n = n.substr(2, n.len() - 1);
        p1 = n.substr(0, 0);
        p3 = n.substr(0, 2);
        base = n;
        imm_form = 1'b1;
        if (n == "NOP" || n == "LUI" || n == "AUIPC") begin
            base = "ADD";
            imm_form = (n != "NOP");
        end else if (n == "SLTIU") begin
            base = "SLTU";
        end else if (n.getc(n.len() - 1) == "I") begin
            base = n.substr(0, n.len() - 2);
        end else if (n != "JAL" && n != "JALR") begin
            imm_form = 1'b0;
        end
        e.req.cmd = issue_pkg::c_NONE;
        k = k.first();
        repeat (k.num()) begin
            if (k.name() == {"c_", base})
                e.req.cmd = k;
            k = k.next();
        end
        if (p1 == "B" || p1 == "J" || p3 == "SLT")
            e.unit = issue_pkg::U_BRANCH;
        else if (p3 == "SLL" || p3 == "SRL" || p3 == "SRA" || p3 == "MUL" || p3 == "DIV"
                 || p3 == "REM")
            e.unit = issue_pkg::U_MULDIV;
        else if ((p1 == "L" && n != "LUI") || n == "SB" || n == "SH" || n == "SW")
            e.unit = issue_pkg::U_LSU;
        else
            e.unit = issue_pkg::U_ALU;
        e.req.arg0 = reg_value(d.rs1);
        e.req.arg1 = imm_form ? d.imm : reg_value(d.rs2);
        e.req.addr = d.addr;
        e.req.imm  = d.imm;
        e.req.rd   = (n == "NOP") ? '0 : d.rd;
        return e;
    endfunction

    function automatic issue_pkg::dec_instr_t rand_instr();
        issue_pkg::dec_instr_t d;
        d.rs1    = 5'($urandom);
        d.rs2    = 5'($urandom);
        d.rd     = 5'($urandom);
        d.imm    = $urandom;
        d.addr   = $urandom;
        d.opcode = issue_pkg::opcode_t'(6'($urandom_range(0, int'(issue_pkg::i_SW))));
        return d;
    endfunction

    always_comb begin
        active = {o_alu.cmd != issue_pkg::c_NONE, o_branch.cmd != issue_pkg::c_NONE,
                  o_muldiv0.cmd != issue_pkg::c_NONE, o_muldiv1.cmd != issue_pkg::c_NONE,
                  o_lsu.cmd != issue_pkg::c_NONE};
        // Idle ports are all zero, so the OR is the one active request
        obs = issue_pkg::unit_req_t'(o_alu | o_branch | o_muldiv0 | o_muldiv1 | o_lsu);
        idle_dirty = idle_bad(o_alu) || idle_bad(o_branch) || idle_bad(o_muldiv0) ||
                     idle_bad(o_muldiv1) || idle_bad(o_lsu);
        if (active[3])
            obs_unit = issue_pkg::U_BRANCH;
        else if (active[2] || active[1])
            obs_unit = issue_pkg::U_MULDIV;
        else if (active[0])
            obs_unit = issue_pkg::U_LSU;
        else
            obs_unit = issue_pkg::U_ALU;
        // Class of the last accepted instruction has a free unit
        case (tail_unit)
            issue_pkg::U_ALU:    target_free = !i_busy.alu;
            issue_pkg::U_BRANCH: target_free = !i_busy.branch;
            issue_pkg::U_MULDIV: target_free = !(i_busy.muldiv0 && i_busy.muldiv1);
            default:             target_free = !i_busy.lsu;
        endcase
    end

    // Ports seen at an edge retire the oldest entry, then acceptance appends
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q.delete();
            head_valid <= 1'b0;
            seen_valid <= 1'b0;
            accept_cnt <= 0;
            tail_unit  <= issue_pkg::U_ALU;
        end else begin
            if (active != '0 && q.size() != 0)
                void'(q.pop_front());
            if (i_flush) begin
                q.delete();
            end else if (i_valid && !o_busy) begin
                q.push_back(expect_of(i_instr));
                accept_cnt <= accept_cnt + 1;
                tail_unit  <= q[q.size() - 1].unit;
            end
            if (i_valid)
                seen_valid <= 1'b1;
            head_valid <= (q.size() != 0);
            if (q.size() != 0)
                head <= q[0];
        end
    end

    a_reset_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        !seen_valid |-> (active == '0 && !o_busy))
        else begin fails++; $display("unit port active or stage busy before any input"); end

    a_ports_clean: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(active) && !idle_dirty)
        else begin fails++; $display("several requests at once or idle port not zero"); end

    a_req_match: assert property (@(posedge clk) disable iff (!rst_n)
        (active != '0) |-> (head_valid && obs_unit == head.unit && obs == head.req))
        else begin
            fails++;
            $display("[ERROR] %s got %h expected %h", port_name($sampled(active)),
                     $sampled(obs), $sampled(head.req));
        end

    a_issue_latency: assert property (@(posedge clk) disable iff (!rst_n)
        ($past(i_valid && !o_busy && !i_flush) && target_free && !i_flush)
            |=> (active != '0))
        else begin fails++; $display("accepted instruction did not issue two edges later"); end

    a_md_pick: assert property (@(posedge clk) disable iff (!rst_n)
        (active[2] || active[1]) |-> (active[1] == $past(i_busy.muldiv0)))
        else begin fails++; $display("muldiv request went to the wrong unit"); end

    a_stall_idle: assert property (@(posedge clk) disable iff (!rst_n)
        o_busy |=> (active == '0))
        else begin fails++; $display("request issued while the stage was stalled"); end

    a_flush_free: assert property (@(posedge clk) disable iff (!rst_n)
        i_flush |=> !o_busy)
        else begin fails++; $display("stage still busy in the cycle after a flush"); end

    task automatic step();
        @(posedge clk);
        #5;
        if (rand_busy)
            i_busy = issue_pkg::unit_busy_t'(5'($urandom));
    endtask

    task automatic send(input issue_pkg::dec_instr_t d);
        int cnt0;
        int n;
        cnt0 = accept_cnt;
        n = 0;
        i_instr = d;
        i_valid = 1'b1;
        while (accept_cnt == cnt0 && n < 64) begin
            step();
            n++;
        end
        i_valid = 1'b0;
        if (accept_cnt == cnt0) begin
            timeouts++;
            $display("instruction was not accepted within 64 cycles");
        end
    endtask

    task automatic wait_until_busy();
        int n;
        n = 0;
        while (!o_busy && n < 8) begin
            step();
            n++;
        end
        if (!o_busy) begin
            timeouts++;
            $display("stage did not raise o_busy under back-pressure");
        end
    endtask

    task automatic drain();
        int n;
        n = 0;
        while (q.size() != 0 && n < 400) begin
            step();
            n++;
        end
        if (q.size() != 0) begin
            timeouts++;
            $display("%0d expected instructions never issued", q.size());
        end
    endtask

    task automatic report_test(input string name, input int err0);
        tests++;
        if (fails + timeouts == err0)
            $display("test %0d %s: ok", tests, name);
        else
            $display("test %0d %s: %0d errors", tests, name, fails + timeouts - err0);
    endtask

    initial begin
        int                    err0;
        issue_pkg::opcode_t    op;
        issue_pkg::dec_instr_t d;
        issue_pkg::opcode_t    stall_ops[3] = '{issue_pkg::i_ADD, issue_pkg::i_BEQ,
                                                issue_pkg::i_LW};
        logic [4:0]            stall_bits[3] = '{5'b10000, 5'b01000, 5'b00001};
        void'($urandom(28546));
        rst_n = 1'b0;
        i_flush = 1'b0;
        i_valid = 1'b0;
        i_instr = '0;
        i_busy = '0;
        rand_busy = 1'b0;
        fails = 0;
        timeouts = 0;
        tests = 0;
        repeat (3) @(posedge clk);
        #5;
        rst_n = 1'b1;

        err0 = fails + timeouts;
        repeat (4) step();
        report_test("reset idle", err0);

        // Every opcode back to back, one issue per cycle
        err0 = fails + timeouts;
        op = op.first();
        repeat (op.num()) begin
            d = rand_instr();
            d.opcode = op;
            send(d);
            op = op.next();
        end
        drain();
        report_test("opcode routing and operands", err0);

        err0 = fails + timeouts;
        i_busy.muldiv0 = 1'b1;
        d = rand_instr();
        d.opcode = issue_pkg::i_MUL;
        send(d);
        drain();
        i_busy.muldiv1 = 1'b1;
        d.opcode = issue_pkg::i_DIV;
        send(d);
        wait_until_busy();
        repeat (3) step();
        i_busy = '0;
        d = rand_instr();
        d.opcode = issue_pkg::i_REMU;
        send(d);
        send(rand_instr());
        drain();
        report_test("muldiv pair choice", err0);

        err0 = fails + timeouts;
        for (int k = 0; k < 3; k++) begin
            i_busy = issue_pkg::unit_busy_t'(stall_bits[k]);
            d = rand_instr();
            d.opcode = stall_ops[k];
            send(d);
            wait_until_busy();
            repeat (2) step();
            i_busy = '0;
            drain();
        end
        rand_busy = 1'b1;
        repeat (80) send(rand_instr());
        rand_busy = 1'b0;
        i_busy = '0;
        drain();
        report_test("busy stall and random back-pressure", err0);

        // Flushed instruction waits in hold behind busy units, which stay busy
        // until the next instruction has been taken
        err0 = fails + timeouts;
        i_busy = '1;
        send(rand_instr());
        wait_until_busy();
        i_flush = 1'b1;
        step();
        i_flush = 1'b0;
        send(rand_instr());
        i_busy = '0;
        drain();
        report_test("flush of a waiting instruction", err0);

        $display("tests: %0d, assertion failures: %0d, timeouts: %0d", tests, fails, timeouts);
        if (fails + timeouts == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

    initial begin
        #1000000;
        $display("simulation time limit reached");
        $display("*** FAILED ***");
        $finish;
    end

endmodule

//--- issuer_top.f
logic/issue_pkg.sv
logic/issue_hold.sv
logic/issue_route.sv
logic/unit_dispatch.sv
logic/issuer_top.sv
verification/issuer_tb.sv

//--- Makefile
# Verilator lint and simulation of the issue stage
VERILATOR ?= verilator
TB_TOP    ?= issuer_tb
RTL_TOP   ?= issuer_top
FILELIST  ?= issuer_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

# The run passes only when the log holds the pass line
sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TB_TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -qF '*** PASSED ***' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
